// ==== common/nnShapePkg.sv ====
// Network dimensions, index widths and the data types of both layers
`default_nettype none

package nnShapePkg;

	// Network shape
	localparam int pixelCount  = 784;
	localparam int hiddenCount = 32;
	localparam int classCount  = 10;

	// Index types
	typedef logic [$clog2(pixelCount)-1:0] pixelIndex_t;
	typedef logic [$clog2(hiddenCount)-1:0] hiddenIndex_t;
	typedef logic [$clog2(classCount)-1:0] classIndex_t;

	// Leaves of the argmax reduction, padded to a power of two
	localparam int argmaxLeaves = 2 ** $bits(classIndex_t);

	// Layer 1 arithmetic, accumulator wraps modulo 2^7
	typedef logic signed [4:0] l1Weight_t;
	typedef logic signed [6:0] hiddenSum_t;
	typedef logic [6:0] hiddenValue_t;

	// Layer 2 arithmetic, accumulator wraps modulo 2^16
	typedef logic signed [5:0] l2Weight_t;
	typedef logic signed [15:0] classSum_t;

	// Rows and vectors, element 0 in the low bits
	typedef l1Weight_t [hiddenCount-1:0] l1Row_t;
	typedef l2Weight_t [classCount-1:0] l2Row_t;
	typedef hiddenValue_t [hiddenCount-1:0] hiddenVector_t;
	typedef classSum_t [classCount-1:0] classVector_t;

endpackage

`default_nettype wire

// ==== common/nnLoadPkg.sv ====
// Layer select and the write word shared by both weight loaders
`default_nettype none

package nnLoadPkg;

	import nnShapePkg::*;

	typedef enum logic {
		layerOne = 1'b0,
		layerTwo = 1'b1
	} layerSel_t;

	// Layer 2 row sits in the low bits, the rest of the word is unused
	typedef struct packed {
		logic [$bits(l1Row_t)-$bits(l2Row_t)-1:0] unused;
		l2Row_t row;
	} l2Padded_t;

	// Same write word, decoded per layer
	// Lane n of l1 feeds hidden node n, lane c of l2 feeds class c
	typedef union packed {
		l1Row_t l1;
		l2Padded_t l2;
	} loadWord_t;

endpackage

`default_nettype wire

// ==== hdl/weightBank.sv ====
// Row memory with synchronous write and combinational read
`timescale 1ns/1ps
`default_nettype none

module weightBank #(
	parameter int rowCount = 32,
	parameter int rowWidth = 60
) (
	input  logic                        clk,
	input  logic                        writeEnable,
	input  logic [$clog2(rowCount)-1:0] writeRow,
	input  logic [$clog2(rowCount)-1:0] readRow,
	input  logic [rowWidth-1:0]         writeData,
	output logic [rowWidth-1:0]         readData
);

	logic [rowWidth-1:0] rows [rowCount];

	always_ff @(posedge clk) begin
		if (writeEnable) begin
			rows[writeRow] <= writeData;
		end
	end

	// Row is visible in the same cycle as its address
	assign readData = rows[readRow];

endmodule

`default_nettype wire

// ==== inputLayer/pixelQueue.sv ====
// Two-bank queue of set-pixel indices with frame counting and bank release
`timescale 1ns/1ps
`default_nettype none

module pixelQueue
	import nnShapePkg::*;
(
	input  logic        clk,
	input  logic        reset,
	input  logic        inputsInbound,
	input  logic        inputPixel,
	input  logic        dequeue,
	output logic        readyForInputs,
	output logic        queueReady,
	output logic        queueEmpty,
	output pixelIndex_t queueIndex
);

	pixelIndex_t slots [2][pixelCount];

	// Fill side
	pixelIndex_t pixelPos;
	pixelIndex_t fillCount;
	logic fillBank;
	logic frameDone;

	// Per-bank state, counts reuse the index type since 784 fits
	logic [1:0] bankFull;
	pixelIndex_t bankCount [2];

	// Drain side
	pixelIndex_t readPtr;
	logic drainBank;
	logic rawEmpty;
	logic lastIndex;
	logic bankRelease;
	logic justDrained;

	assign frameDone = inputsInbound && (pixelPos == pixelIndex_t'(pixelCount - 1));

	// Source stalls only once both banks hold a frame
	assign readyForInputs = ~(bankFull[0] & bankFull[1]);

	// --------------------------------------------------------------------------
	// Fill side
	// --------------------------------------------------------------------------

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			pixelPos <= '0;
			fillCount <= '0;
			fillBank <= 1'b0;
		end else if (inputsInbound) begin
			if (frameDone) begin
				pixelPos <= '0;
				fillCount <= '0;
				fillBank <= ~fillBank;
			end else begin
				pixelPos <= pixelPos + 1'b1;
				fillCount <= fillCount + pixelIndex_t'(inputPixel);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (inputsInbound && inputPixel) begin
			slots[fillBank][fillCount] <= pixelPos;
		end
	end

	// Fill and drain never touch the same bank in one cycle
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			bankFull <= '0;
			bankCount[0] <= '0;
			bankCount[1] <= '0;
		end else begin
			if (bankRelease) begin
				bankFull[drainBank] <= 1'b0;
			end
			if (frameDone) begin
				bankFull[fillBank] <= 1'b1;
				bankCount[fillBank] <= fillCount + pixelIndex_t'(inputPixel);
			end
		end
	end

	// --------------------------------------------------------------------------
	// Drain side
	// --------------------------------------------------------------------------

	assign queueReady = bankFull[drainBank];
	assign queueIndex = slots[drainBank][readPtr];
	assign rawEmpty = (readPtr == bankCount[drainBank]);
	assign lastIndex = (readPtr + 1'b1 == bankCount[drainBank]);

	// Empty frames are released by a dequeue that finds nothing
	assign bankRelease = dequeue & queueReady & (rawEmpty | lastIndex);

	// Drained bank still reads empty for the cycle after its last index
	assign queueEmpty = justDrained | rawEmpty;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			readPtr <= '0;
			drainBank <= 1'b0;
			justDrained <= 1'b0;
		end else begin
			justDrained <= bankRelease & ~rawEmpty;
			if (bankRelease) begin
				readPtr <= '0;
				drainBank <= ~drainBank;
			end else if (dequeue && queueReady) begin
				readPtr <= readPtr + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== hiddenLayer/hiddenLayer.sv ====
// Layer 1 sequencer with 32 accumulators, bias row, ReLU and output register
`timescale 1ns/1ps
`default_nettype none

module hiddenLayer
	import nnShapePkg::*;
	import nnLoadPkg::*;
(
	input  logic          clk,
	input  logic          reset,
	input  logic          queueReady,
	input  logic          queueEmpty,
	input  pixelIndex_t   queueIndex,
	input  logic          weightWriteEnable,
	input  logic          biasWriteEnable,
	input  layerSel_t     layerSelect,
	input  pixelIndex_t   writeAddress,
	input  loadWord_t     writeWord,
	input  l1Row_t        bankRow,
	input  logic          hiddenTaken,
	output logic          dequeue,
	output pixelIndex_t   bankAddress,
	output logic          bankWrite,
	output logic          hiddenReady,
	output hiddenVector_t hiddenValues
);

	logic running;
	logic firstStep;
	logic start;
	logic accumulate;
	logic finish;
	logic biasWrite;

	l1Row_t biasRow;
	hiddenSum_t acc [hiddenCount];

	// Weight and bias loading
	assign bankWrite = weightWriteEnable & (layerSelect == layerOne);
	assign biasWrite = biasWriteEnable & (layerSelect == layerOne);
	assign bankAddress = bankWrite ? writeAddress : queueIndex;

	// New frame only once the previous result has left the output register
	assign start = ~running & queueReady & ~hiddenReady;
	assign accumulate = running & ~queueEmpty;
	assign finish = running & queueEmpty;

	// First step also pops an empty frame so its bank is released
	assign dequeue = running & (~queueEmpty | firstStep);

	// --------------------------------------------------------------------------
	// Sequencer
	// --------------------------------------------------------------------------

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			running <= 1'b0;
			firstStep <= 1'b0;
			hiddenReady <= 1'b0;
		end else begin
			if (start) begin
				running <= 1'b1;
				firstStep <= 1'b1;
			end else if (running) begin
				firstStep <= 1'b0;
				if (queueEmpty) begin
					running <= 1'b0;
					hiddenReady <= 1'b1;
				end
			end
			if (hiddenTaken) begin
				hiddenReady <= 1'b0;
			end
		end
	end

	// --------------------------------------------------------------------------
	// Accumulators and ReLU
	// --------------------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (biasWrite) begin
			biasRow <= writeWord.l1;
		end
		for (int n = 0; n < hiddenCount; n++) begin
			if (start) begin
				acc[n] <= hiddenSum_t'(biasRow[n]);
			end else if (accumulate) begin
				// Sign-extended weight, sum wraps at 7 bits
				acc[n] <= acc[n] + hiddenSum_t'(bankRow[n]);
			end
			if (finish) begin
				hiddenValues[n] <= acc[n][$bits(hiddenSum_t)-1] ? '0 : hiddenValue_t'(acc[n]);
			end
		end
	end

endmodule

`default_nettype wire

// ==== outputLayer/argmaxTree.sv ====
// Signed argmax over the class sums, lowest index wins a tie
`timescale 1ns/1ps
`default_nettype none

module argmaxTree
	import nnShapePkg::*;
(
	input  classVector_t sums,
	output classIndex_t  winner
);

	classSum_t levelSum [argmaxLeaves];
	classIndex_t levelIdx [argmaxLeaves];

	always_comb begin
		// Unused leaves hold the most negative sum and a high index
		for (int i = 0; i < argmaxLeaves; i++) begin
			levelSum[i] = (i < classCount) ? sums[i] : {1'b1, {($bits(classSum_t)-1){1'b0}}};
			levelIdx[i] = classIndex_t'(i);
		end
		// Pairwise levels, left operand always covers the lower indices
		for (int width = argmaxLeaves / 2; width > 0; width = width / 2) begin
			for (int k = 0; k < width; k++) begin
				if (levelSum[2*k+1] > levelSum[2*k]) begin
					levelSum[k] = levelSum[2*k+1];
					levelIdx[k] = levelIdx[2*k+1];
				end else begin
					levelSum[k] = levelSum[2*k];
					levelIdx[k] = levelIdx[2*k];
				end
			end
		end
		winner = levelIdx[0];
	end

endmodule

`default_nettype wire

// ==== outputLayer/outputLayer.sv ====
// Layer 2 sequencer with 10 multiply-accumulators, bias row and prediction register
`timescale 1ns/1ps
`default_nettype none

module outputLayer
	import nnShapePkg::*;
	import nnLoadPkg::*;
(
	input  logic          clk,
	input  logic          reset,
	input  logic          hiddenReady,
	input  hiddenVector_t hiddenValues,
	input  logic          weightWriteEnable,
	input  logic          biasWriteEnable,
	input  layerSel_t     layerSelect,
	input  pixelIndex_t   writeAddress,
	input  loadWord_t     writeWord,
	input  l2Row_t        bankRow,
	input  logic          predictionReceived,
	output logic          hiddenTaken,
	output hiddenIndex_t  bankAddress,
	output logic          bankWrite,
	output logic          predictionReady,
	output classIndex_t   predictionOut
);

	logic busy;
	logic accumulating;
	logic biasWrite;
	hiddenIndex_t nodeCount;

	hiddenVector_t hiddenCopy;
	l2Row_t biasRow;
	classVector_t sums;
	classIndex_t winner;

	// Only the low address bits select a layer 2 row
	assign bankWrite = weightWriteEnable & (layerSelect == layerTwo);
	assign biasWrite = biasWriteEnable & (layerSelect == layerTwo);
	assign bankAddress = bankWrite ? writeAddress[$bits(hiddenIndex_t)-1:0] : nodeCount;

	// Take a vector only while idle and the last prediction has been read
	assign hiddenTaken = hiddenReady & ~predictionReady & ~busy;

	argmaxTree argmax_i (
		.sums   (sums),
		.winner (winner)
	);

	// --------------------------------------------------------------------------
	// Sequencer: take, 32 accumulate steps, argmax
	// --------------------------------------------------------------------------

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			busy <= 1'b0;
			accumulating <= 1'b0;
			nodeCount <= '0;
			predictionReady <= 1'b0;
		end else begin
			if (hiddenTaken) begin
				busy <= 1'b1;
				accumulating <= 1'b1;
				nodeCount <= '0;
			end else if (accumulating) begin
				nodeCount <= nodeCount + 1'b1;
				if (nodeCount == hiddenIndex_t'(hiddenCount - 1)) begin
					accumulating <= 1'b0;
				end
			end else if (busy) begin
				busy <= 1'b0;
				predictionReady <= 1'b1;
			end
			if (predictionReceived) begin
				predictionReady <= 1'b0;
			end
		end
	end

	// --------------------------------------------------------------------------
	// Datapath
	// --------------------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (biasWrite) begin
			biasRow <= writeWord.l2.row;
		end
		if (hiddenTaken) begin
			hiddenCopy <= hiddenValues;
		end
		for (int c = 0; c < classCount; c++) begin
			if (hiddenTaken) begin
				sums[c] <= classSum_t'(biasRow[c]);
			end else if (accumulating) begin
				// Hidden value is unsigned, product wraps at 16 bits
				sums[c] <= sums[c] + classSum_t'(bankRow[c]) *
					classSum_t'(hiddenCopy[nodeCount]);
			end
		end
		if (busy && !accumulating && !hiddenTaken) begin
			predictionOut <= winner;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/nnClassifier.sv ====
// Classifier top level with pixel queue, both layers and their weight banks
`timescale 1ns/1ps
`default_nettype none

module nnClassifier
	import nnShapePkg::*;
	import nnLoadPkg::*;
(
	input  logic        clk,
	input  logic        reset,
	input  logic        inputsInbound,
	input  logic        inputPixel,
	input  logic        weightWriteEnable,
	input  logic        biasWriteEnable,
	input  layerSel_t   layerSelect,
	input  pixelIndex_t writeAddress,
	input  loadWord_t   writeWord,
	input  logic        predictionReceived,
	output logic        readyForInputs,
	output logic        predictionReady,
	output classIndex_t predictionOut
);

	// Queue to hidden layer
	logic dequeue;
	logic queueReady;
	logic queueEmpty;
	pixelIndex_t queueIndex;

	// Layer 1 bank
	pixelIndex_t l1Address;
	logic l1Write;
	l1Row_t l1Row;

	// Hidden layer to output layer
	logic hiddenReady;
	logic hiddenTaken;
	hiddenVector_t hiddenValues;

	// Layer 2 bank
	hiddenIndex_t l2Address;
	logic l2Write;
	l2Row_t l2Row;

	pixelQueue queue_i (
		.clk            (clk),
		.reset          (reset),
		.inputsInbound  (inputsInbound),
		.inputPixel     (inputPixel),
		.dequeue        (dequeue),
		.readyForInputs (readyForInputs),
		.queueReady     (queueReady),
		.queueEmpty     (queueEmpty),
		.queueIndex     (queueIndex)
	);

	weightBank #(
		.rowCount (pixelCount),
		.rowWidth ($bits(l1Row_t))
	) l1Bank (
		.clk         (clk),
		.writeEnable (l1Write),
		.writeRow    (l1Address),
		.readRow     (l1Address),
		.writeData   (writeWord.l1),
		.readData    (l1Row)
	);

	hiddenLayer hidden_i (
		.clk               (clk),
		.reset             (reset),
		.queueReady        (queueReady),
		.queueEmpty        (queueEmpty),
		.queueIndex        (queueIndex),
		.weightWriteEnable (weightWriteEnable),
		.biasWriteEnable   (biasWriteEnable),
		.layerSelect       (layerSelect),
		.writeAddress      (writeAddress),
		.writeWord         (writeWord),
		.bankRow           (l1Row),
		.hiddenTaken       (hiddenTaken),
		.dequeue           (dequeue),
		.bankAddress       (l1Address),
		.bankWrite         (l1Write),
		.hiddenReady       (hiddenReady),
		.hiddenValues      (hiddenValues)
	);

	weightBank #(
		.rowCount (hiddenCount),
		.rowWidth ($bits(l2Row_t))
	) l2Bank (
		.clk         (clk),
		.writeEnable (l2Write),
		.writeRow    (l2Address),
		.readRow     (l2Address),
		.writeData   (writeWord.l2.row),
		.readData    (l2Row)
	);

	outputLayer output_i (
		.clk                (clk),
		.reset              (reset),
		.hiddenReady        (hiddenReady),
		.hiddenValues       (hiddenValues),
		.weightWriteEnable  (weightWriteEnable),
		.biasWriteEnable    (biasWriteEnable),
		.layerSelect        (layerSelect),
		.writeAddress       (writeAddress),
		.writeWord          (writeWord),
		.bankRow            (l2Row),
		.predictionReceived (predictionReceived),
		.hiddenTaken        (hiddenTaken),
		.bankAddress        (l2Address),
		.bankWrite          (l2Write),
		.predictionReady    (predictionReady),
		.predictionOut      (predictionOut)
	);

endmodule

`default_nettype wire

// ==== test/nnClassifier_props.sv ====
// Bound assertions on the prediction hold and frame start protocol
`timescale 1ns/1ps
`default_nettype none

module nnClassifier_props
	import nnShapePkg::*;
(
	input logic        clk,
	input logic        reset,
	input logic        predictionReady,
	input logic        predictionReceived,
	input logic        readyForInputs,
	input logic        inputsInbound,
	input classIndex_t predictionOut
);

	int violations = 0;

	// Held result stays put until acknowledged
	heldResult: assert property (@(posedge clk) disable iff (reset)
		predictionReady && !predictionReceived |=> $stable(predictionOut))
	else begin
		violations++;
		$error("predictionOut changed while the prediction was held");
	end

	knownLevels: assert property (@(posedge clk) disable iff (reset)
		!$isunknown({predictionReady, readyForInputs}))
	else begin
		violations++;
		$error("predictionReady or readyForInputs is unknown");
	end

	// Source must respect a stalled queue
	frameStart: assert property (@(posedge clk) disable iff (reset)
		$rose(inputsInbound) |-> readyForInputs)
	else begin
		violations++;
		$error("frame started while readyForInputs was low");
	end

endmodule

`default_nettype wire

// ==== test/nnModel.svh ====
// Reference model for hidden values, class sums and the predicted digit
`ifndef NN_MODEL_SVH
`define NN_MODEL_SVH

// Bias plus the weights of every set pixel, kept to 7 bits, then ReLU
function automatic hiddenVector_t modelHidden(input frame_t frame);
	hiddenVector_t values;
	int total;
	logic [6:0] wrapped;
	for (int n = 0; n < hiddenCount; n++) begin
		total = int'($signed(l1Bias[n]));
		for (int p = 0; p < pixelCount; p++) begin
			if (frame[p]) begin
				total += int'($signed(l1Weights[p][n]));
			end
		end
		wrapped = total[6:0];
		values[n] = wrapped[6] ? 7'd0 : wrapped;
	end
	return values;
endfunction

// Bias plus signed weight times unsigned hidden value, kept to 16 bits
function automatic classVector_t modelSums(input hiddenVector_t hidden);
	classVector_t sums;
	int total;
	for (int c = 0; c < classCount; c++) begin
		total = int'($signed(l2Bias[c]));
		for (int n = 0; n < hiddenCount; n++) begin
			total += int'($signed(l2Weights[n][c])) * int'(hidden[n]);
		end
		sums[c] = total[15:0];
	end
	return sums;
endfunction

// Largest signed sum, first one found wins a tie
function automatic classIndex_t modelArgmax(input classVector_t sums);
	int best;
	best = 0;
	for (int c = 1; c < classCount; c++) begin
		if ($signed(sums[c]) > $signed(sums[best])) begin
			best = c;
		end
	end
	return classIndex_t'(best);
endfunction

function automatic classIndex_t modelPredict(input frame_t frame);
	return modelArgmax(modelSums(modelHidden(frame)));
endfunction

`endif

// ==== test/nnClassifierTb.sv ====
// Testbench with clock, reset, random loading and frames, scoreboard and compare tasks
`timescale 1ns/1ps
`default_nettype none

module nnClassifierTb
	import nnShapePkg::*;
	import nnLoadPkg::*;
();

	localparam int waitLimit = 8000;

	typedef logic [pixelCount-1:0] frame_t;

	logic clk;
	logic reset;
	logic inputsInbound;
	logic inputPixel;
	logic weightWriteEnable;
	logic biasWriteEnable;
	layerSel_t layerSelect;
	pixelIndex_t writeAddress;
	loadWord_t writeWord;
	logic predictionReceived;
	logic readyForInputs;
	logic predictionReady;
	classIndex_t predictionOut;

	// Model copy of the loaded weights
	l1Row_t l1Weights [pixelCount];
	l1Row_t l1Bias;
	l2Row_t l2Weights [hiddenCount];
	l2Row_t l2Bias;

	// Scoreboard
	frame_t frameQ [$];
	classIndex_t expectQ [$];

	`include "nnModel.svh"

	always begin
		clk = 1'b0;
		#20;
		clk = 1'b1;
		#20;
	end

	nnClassifier dut_i (
		.clk                (clk),
		.reset              (reset),
		.inputsInbound      (inputsInbound),
		.inputPixel         (inputPixel),
		.weightWriteEnable  (weightWriteEnable),
		.biasWriteEnable    (biasWriteEnable),
		.layerSelect        (layerSelect),
		.writeAddress       (writeAddress),
		.writeWord          (writeWord),
		.predictionReceived (predictionReceived),
		.readyForInputs     (readyForInputs),
		.predictionReady    (predictionReady),
		.predictionOut      (predictionOut)
	);

	bind nnClassifier nnClassifier_props props_i (
		.clk                (clk),
		.reset              (reset),
		.predictionReady    (predictionReady),
		.predictionReceived (predictionReceived),
		.readyForInputs     (readyForInputs),
		.inputsInbound      (inputsInbound),
		.predictionOut      (predictionOut)
	);

	task automatic stopWithFailure(input string why);
		$display("%s", why);
		$display("Test failures found");
		$fatal(1, "simulation stopped after a failure");
	endtask

	task automatic checkClass(input string name, input classIndex_t expected,
			input classIndex_t actual);
		if (actual !== expected) begin
			stopWithFailure($sformatf("error: %s expected %0d actual %0d", name, expected, actual));
		end
	endtask

	task automatic checkLevel(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			stopWithFailure($sformatf("error: %s expected %b actual %b", name, expected, actual));
		end
	endtask

	always @(negedge clk) begin
		if (dut_i.props_i.violations != 0) begin
			stopWithFailure("a bound assertion failed");
		end
	end

	// ------------------------------------------------------------------------
	// Loading
	// ------------------------------------------------------------------------

	task automatic writeRow(input layerSel_t sel, input logic isBias, input pixelIndex_t addr,
			input loadWord_t word);
		@(posedge clk);
		weightWriteEnable <= ~isBias;
		biasWriteEnable <= isBias;
		layerSelect <= sel;
		writeAddress <= addr;
		writeWord <= word;
	endtask

	task automatic endWrites();
		@(posedge clk);
		weightWriteEnable <= 1'b0;
		biasWriteEnable <= 1'b0;
	endtask

	task automatic loadRandomLayerOne();
		loadWord_t word;
		for (int p = 0; p < pixelCount; p++) begin
			for (int n = 0; n < hiddenCount; n++) begin
				l1Weights[p][n] = l1Weight_t'($urandom);
			end
			word.l1 = l1Weights[p];
			writeRow(layerOne, 1'b0, pixelIndex_t'(p), word);
		end
		for (int n = 0; n < hiddenCount; n++) begin
			l1Bias[n] = l1Weight_t'($urandom);
		end
		word.l1 = l1Bias;
		writeRow(layerOne, 1'b1, '0, word);
		endWrites();
	endtask

	// Writes the model's layer 2 rows with junk in the unused bits and address
	task automatic loadLayerTwo();
		loadWord_t word;
		pixelIndex_t addr;
		for (int n = 0; n < hiddenCount; n++) begin
			word = {$urandom, $urandom, $urandom, $urandom, $urandom};
			word.l2.row = l2Weights[n];
			addr = pixelIndex_t'(n) | (pixelIndex_t'($urandom) & 10'h3e0);
			writeRow(layerTwo, 1'b0, addr, word);
		end
		word = {$urandom, $urandom, $urandom, $urandom, $urandom};
		word.l2.row = l2Bias;
		writeRow(layerTwo, 1'b1, pixelIndex_t'($urandom), word);
		endWrites();
	endtask

	task automatic randomizeLayerTwo();
		for (int n = 0; n < hiddenCount; n++) begin
			for (int c = 0; c < classCount; c++) begin
				l2Weights[n][c] = l2Weight_t'($urandom);
			end
		end
		for (int c = 0; c < classCount; c++) begin
			l2Bias[c] = l2Weight_t'($urandom);
		end
	endtask

	// ------------------------------------------------------------------------
	// Frames and results
	// ------------------------------------------------------------------------

	function automatic frame_t randomFrame();
		frame_t frame;
		for (int p = 0; p < pixelCount; p++) begin
			frame[p] = ($urandom % 5) == 0;
		end
		return frame;
	endfunction

	task automatic addFrame(input frame_t frame);
		frameQ.push_back(frame);
		expectQ.push_back(modelPredict(frame));
	endtask

	task automatic addFrameExpect(input frame_t frame, input classIndex_t expected);
		frameQ.push_back(frame);
		expectQ.push_back(expected);
	endtask

	task automatic waitForInputReady();
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (readyForInputs !== 1'b1) begin
			cycles++;
			if (cycles > waitLimit) begin
				stopWithFailure("timeout while waiting for readyForInputs");
			end
			@(negedge clk);
		end
	endtask

	task automatic sendFrame(input frame_t frame);
		waitForInputReady();
		for (int p = 0; p < pixelCount; p++) begin
			@(posedge clk);
			inputsInbound <= 1'b1;
			inputPixel <= frame[p];
		end
		@(posedge clk);
		inputsInbound <= 1'b0;
		inputPixel <= 1'b0;
	endtask

	// Receiver holds off until the queue stalls the source
	task automatic waitForStall(input string name);
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (readyForInputs !== 1'b0) begin
			cycles++;
			if (cycles > waitLimit) begin
				stopWithFailure("readyForInputs never fell while predictions were withheld");
			end
			@(negedge clk);
		end
		checkLevel({name, " held predictionReady"}, 1'b1, predictionReady);
	endtask

	task automatic receivePrediction(input string name);
		int cycles;
		classIndex_t expected;
		cycles = 0;
		@(negedge clk);
		while (predictionReady !== 1'b1) begin
			cycles++;
			if (cycles > waitLimit) begin
				stopWithFailure("timeout while waiting for predictionReady");
			end
			@(negedge clk);
		end
		if (expectQ.size() == 0) begin
			stopWithFailure("prediction arrived with no frame outstanding");
		end
		expected = expectQ.pop_front();
		checkClass(name, expected, predictionOut);
		@(posedge clk);
		predictionReceived <= 1'b1;
		@(posedge clk);
		predictionReceived <= 1'b0;
	endtask

	task automatic runBatch(input string name, input logic stall);
		int count;
		count = frameQ.size();
		fork
			begin
				for (int i = 0; i < count; i++) begin
					sendFrame(frameQ[i]);
				end
			end
			begin
				if (stall) begin
					waitForStall(name);
				end
				for (int i = 0; i < count; i++) begin
					receivePrediction($sformatf("%s result %0d", name, i));
				end
			end
		join
		frameQ.delete();
	endtask

	initial begin
		void'($urandom(32'h7f4a4207));
		reset = 1'b1;
		inputsInbound = 1'b0;
		inputPixel = 1'b0;
		weightWriteEnable = 1'b0;
		biasWriteEnable = 1'b0;
		layerSelect = layerOne;
		writeAddress = '0;
		writeWord = '0;
		predictionReceived = 1'b0;
		repeat (5) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		checkLevel("reset readyForInputs", 1'b1, readyForInputs);
		checkLevel("reset predictionReady", 1'b0, predictionReady);

		loadRandomLayerOne();
		randomizeLayerTwo();
		loadLayerTwo();
		repeat (20) addFrame(randomFrame());
		runBatch("random frames", 1'b0);

		// Empty frame leaves only the biases, full frame wraps the sums
		addFrame('0);
		addFrame('1);
		runBatch("edge frames", 1'b0);

		// Zero layer 2 weights so the biases alone decide
		for (int n = 0; n < hiddenCount; n++) begin
			l2Weights[n] = '0;
		end
		for (int c = 0; c < classCount; c++) begin
			l2Bias[c] = 6'sd5;
		end
		loadLayerTwo();
		addFrameExpect(randomFrame(), classIndex_t'(0));
		runBatch("tie all equal", 1'b0);
		l2Bias[7] = 6'sd12;
		loadLayerTwo();
		addFrameExpect(randomFrame(), classIndex_t'(7));
		runBatch("largest bias", 1'b0);
		l2Bias[2] = 6'sd20;
		l2Bias[6] = 6'sd20;
		loadLayerTwo();
		addFrameExpect(randomFrame(), classIndex_t'(2));
		runBatch("tie two maxima", 1'b0);

		randomizeLayerTwo();
		loadLayerTwo();
		repeat (6) addFrame(randomFrame());
		runBatch("back-pressure", 1'b1);

		// Assertions on the last acknowledge edge report before the verdict
		@(negedge clk);
		if (dut_i.props_i.violations == 0) begin
			$display("All tests passed!");
			$finish;
		end else begin
			$display("a bound assertion failed");
			$display("Test failures found");
			$fatal(1, "simulation stopped after a failure");
		end
	end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+test
common/nnShapePkg.sv
common/nnLoadPkg.sv
hdl/weightBank.sv
inputLayer/pixelQueue.sv
hiddenLayer/hiddenLayer.sv
outputLayer/argmaxTree.sv
outputLayer/outputLayer.sv
hdl/nnClassifier.sv
test/nnClassifier_props.sv
test/nnClassifierTb.sv

// ==== Bender.yml ====
package:
  name: nn_classifier

sources:
  - files:
      - common/nnShapePkg.sv
      - common/nnLoadPkg.sv
      - hdl/weightBank.sv
      - inputLayer/pixelQueue.sv
      - hiddenLayer/hiddenLayer.sv
      - outputLayer/argmaxTree.sv
      - outputLayer/outputLayer.sv
      - hdl/nnClassifier.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/nnClassifier_props.sv
      - test/nnClassifierTb.sv
